// ==== rtl/vm16_pkg.sv ====
// Shared ISA, memory map and bus types for the vm16 core
// TIM sits at TIM_BASE and every other data address goes out over APB
`default_nettype none

package vm16_pkg;

    // Widths
    localparam int DATA_W    = 16;
    localparam int REG_SEL_W = 3;
    localparam int OP_W      = 5;
    localparam int ALU_OP_W  = 5;

    // Memory sizes and data address map
    localparam int INSTR_DEPTH = 64;
    localparam int INSTR_AW    = $clog2(INSTR_DEPTH);
    localparam int TIM_DEPTH   = 64;
    localparam int TIM_AW      = $clog2(TIM_DEPTH);
    localparam logic [DATA_W-1:0] TIM_BASE = 16'h0000;

    // Opcodes
    localparam logic [OP_W-1:0] OP_NOP     = 5'd0;
    localparam logic [OP_W-1:0] OP_LW      = 5'd1;
    localparam logic [OP_W-1:0] OP_SW      = 5'd2;
    localparam logic [OP_W-1:0] OP_MOV     = 5'd3;
    localparam logic [OP_W-1:0] OP_MOVI    = 5'd4;
    localparam logic [OP_W-1:0] OP_ARITH_U = 5'd5;
    localparam logic [OP_W-1:0] OP_ARITH_S = 5'd6;
    localparam logic [OP_W-1:0] OP_BIT     = 5'd7;
    localparam logic [OP_W-1:0] OP_CMP     = 5'd8;
    localparam logic [OP_W-1:0] OP_BR      = 5'd9;

    // Sub-operations carried in simm5
    localparam logic [4:0] SUB_ADD   = 5'b11111;
    localparam logic [4:0] SUB_SUB   = 5'b11110;
    localparam logic [4:0] SUB_OR    = 5'd0;
    localparam logic [4:0] SUB_XOR   = 5'd1;
    localparam logic [4:0] SUB_AND   = 5'd2;
    localparam logic [4:0] SUB_NOT   = 5'd3;
    localparam logic [4:0] SUB_LSHFT = 5'd4;
    localparam logic [4:0] SUB_RSHFT = 5'd5;

    // Branch conditions carried in imm8
    localparam logic [7:0] BR_U = 8'd0;
    localparam logic [7:0] BR_E = 8'd1;
    localparam logic [7:0] BR_L = 8'd2;

    // Compare result bits
    localparam int FLAG_Z = 0;
    localparam int FLAG_L = 1;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_NOP, ALU_PASS_B, ALU_OR, ALU_XOR, ALU_AND, ALU_NOT, ALU_LSHFT,
        ALU_RSHFT, ALU_UADD, ALU_USUB, ALU_SADD, ALU_SSUB, ALU_CMP
    } alu_op_e;

    typedef struct packed {
        logic [OP_W-1:0]      opcode;
        logic [REG_SEL_W-1:0] rd;
        logic [REG_SEL_W-1:0] ra;
        logic [4:0]           simm5;
    } vm16_instr_reg_t;

    typedef struct packed {
        logic [OP_W-1:0]      opcode;
        logic [REG_SEL_W-1:0] rd;
        logic [7:0]           imm8;
    } vm16_instr_imm_t;

    // One instruction word, register form or immediate form
    typedef union packed {
        vm16_instr_reg_t r;
        vm16_instr_imm_t i;
    } vm16_instr_t;

    typedef struct packed {
        alu_op_e alu_op;
        logic    has_imm4;
        logic    has_imm8;
        logic    has_we;
        logic    has_br;
        logic    has_mem;
        logic    has_mem_we;
        logic    has_cmp;
    } dec_ctrl_t;

    typedef struct packed {
        logic [DATA_W-1:0] paddr;
        logic              pwrite;
        logic              psel;
        logic              penable;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/vm16_bram.sv ====
// Single-port RAM, one cycle read latency, write-first, zero at power-up
`timescale 1ns/100ps
`default_nettype none

module vm16_bram import vm16_pkg::*; #(
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [DATA_W-1:0]        wdata,
    input  logic                     we,
    output logic [DATA_W-1:0]        rdata
);

    logic [DATA_W-1:0] mem [DEPTH] = '{default: '0};

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            // New data shows on the read port
            rdata     <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/vm16_regfile.sv ====
// Eight general registers, asynchronous read, write at the clock edge
`timescale 1ns/100ps
`default_nettype none

module vm16_regfile import vm16_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [REG_SEL_W-1:0] rs,
    output logic [DATA_W-1:0]    rdata,
    input  logic                 we,
    input  logic [REG_SEL_W-1:0] ws,
    input  logic [DATA_W-1:0]    wdata
);

    localparam int NUM_REGS = 2 ** REG_SEL_W;

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[ws] <= wdata;
        end
    end

    assign rdata = regs[rs];

endmodule

`default_nettype wire

// ==== rtl/vm16_decoder.sv ====
// Instruction decoder, purely combinational
// Unknown opcodes and sub-codes decode to a NOP with every flag clear
`timescale 1ns/100ps
`default_nettype none

module vm16_decoder import vm16_pkg::*; (
    input  vm16_instr_t instr,
    output dec_ctrl_t   ctrl
);

    logic       is_signed;
    logic [4:0] sub;

    assign is_signed = (instr.r.opcode == OP_ARITH_S);
    assign sub       = instr.r.simm5;

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_NOP;
        case (instr.r.opcode)
            OP_LW: begin
                ctrl.alu_op  = ALU_PASS_B;
                ctrl.has_mem = 1'b1;
                ctrl.has_we  = 1'b1;
            end
            OP_SW: begin
                ctrl.alu_op     = ALU_PASS_B;
                ctrl.has_mem    = 1'b1;
                ctrl.has_mem_we = 1'b1;
            end
            OP_MOV: begin
                ctrl.alu_op = ALU_PASS_B;
                ctrl.has_we = 1'b1;
            end
            OP_MOVI: begin
                ctrl.alu_op   = ALU_PASS_B;
                ctrl.has_imm8 = 1'b1;
                ctrl.has_we   = 1'b1;
            end
            OP_ARITH_U, OP_ARITH_S: begin
                // Top bit clear means ra plus imm4, then an add
                ctrl.has_imm4 = ~sub[4];
                if (ctrl.has_imm4 || sub == SUB_ADD) begin
                    ctrl.alu_op = is_signed ? ALU_SADD : ALU_UADD;
                end else if (sub == SUB_SUB) begin
                    ctrl.alu_op = is_signed ? ALU_SSUB : ALU_USUB;
                end
                ctrl.has_we = (ctrl.alu_op != ALU_NOP);
            end
            OP_BIT: begin
                case (sub)
                    SUB_OR:    ctrl.alu_op = ALU_OR;
                    SUB_XOR:   ctrl.alu_op = ALU_XOR;
                    SUB_AND:   ctrl.alu_op = ALU_AND;
                    SUB_NOT:   ctrl.alu_op = ALU_NOT;
                    SUB_LSHFT: ctrl.alu_op = ALU_LSHFT;
                    SUB_RSHFT: ctrl.alu_op = ALU_RSHFT;
                    default:   ctrl.alu_op = ALU_NOP;
                endcase
                ctrl.has_we = (ctrl.alu_op != ALU_NOP);
            end
            OP_CMP: begin
                ctrl.alu_op  = ALU_CMP;
                ctrl.has_cmp = 1'b1;
            end
            OP_BR: begin
                // Condition sits in imm8, target is register rd
                ctrl.has_br   = 1'b1;
                ctrl.has_imm8 = 1'b1;
            end
            default: ctrl.alu_op = ALU_NOP;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/vm16_alu.sv ====
// Combinational ALU, a is the rd operand and b the second operand
// Compare is unsigned and only sets FLAG_Z and FLAG_L
`timescale 1ns/100ps
`default_nettype none

module vm16_alu import vm16_pkg::*; (
    input  alu_op_e           op,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    output logic [DATA_W-1:0] c
);

    always_comb begin
        c = '0;
        case (op)
            // Moves, immediates and memory addresses
            ALU_PASS_B: c = b;
            ALU_OR:     c = a | b;
            ALU_XOR:    c = a ^ b;
            ALU_AND:    c = a & b;
            ALU_NOT:    c = ~b;
            // b is the shift amount
            ALU_LSHFT:  c = a << b;
            ALU_RSHFT:  c = a >> b;
            ALU_UADD:   c = a + b;
            ALU_USUB:   c = a - b;
            ALU_SADD:   c = DATA_W'($signed(a) + $signed(b));
            ALU_SSUB:   c = DATA_W'($signed(a) - $signed(b));
            ALU_CMP: begin
                c[FLAG_Z] = (a == b);
                c[FLAG_L] = (a < b);
            end
            default:    c = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/vm16_mmu.sv ====
// Data memory unit, TIM window served locally, all else via APB master
// req is a one-cycle pulse; busy stays high until the access is done
`timescale 1ns/100ps
`default_nettype none

module vm16_mmu import vm16_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              req,
    input  logic [DATA_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  logic              we,
    output logic              busy,
    output logic [DATA_W-1:0] rdata,
    output apb_req_t          apb_req,
    input  apb_rsp_t          apb_rsp
);

    typedef enum logic [1:0] {
        M_IDLE,
        M_ACCESS,
        M_FINISH
    } mmu_state_e;

    mmu_state_e        state;
    logic [DATA_W-1:0] tim_off;
    logic              tim_en;
    logic              tim_we;
    logic [DATA_W-1:0] tim_rdata;
    logic [DATA_W-1:0] apb_rdata;
    logic              apb_done;

    // TIM window decode
    assign tim_off = addr - TIM_BASE;
    assign tim_en  = (tim_off < TIM_DEPTH);
    assign tim_we  = req && we && tim_en;

    // Access phase completes when the slave raises pready
    assign apb_done = apb_req.penable && apb_rsp.pready;

    assign busy  = req || (state == M_ACCESS);
    assign rdata = tim_en ? tim_rdata : apb_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= M_IDLE;
            apb_req <= '0;
        end else begin
            case (state)
                M_IDLE: begin
                    if (req && !tim_en) begin
                        // Setup phase starts next cycle
                        apb_req.paddr  <= addr;
                        apb_req.pwdata <= wdata;
                        apb_req.pwrite <= we;
                        apb_req.psel   <= 1'b1;
                        state          <= M_ACCESS;
                    end
                end
                M_ACCESS: begin
                    if (!apb_req.penable) begin
                        apb_req.penable <= 1'b1;
                    end else if (apb_rsp.pready) begin
                        apb_req <= '0;
                        state   <= M_FINISH;
                    end
                end
                // Read data is held here for writeback
                M_FINISH: state <= M_IDLE;
                default:  state <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == M_ACCESS && apb_done) begin
            apb_rdata <= apb_rsp.prdata;
        end
    end

    vm16_bram #(
        .DEPTH (TIM_DEPTH)
    ) tim_i (
        .clk   (clk),
        .addr  (tim_off[TIM_AW-1:0]),
        .wdata (wdata),
        .we    (tim_we),
        .rdata (tim_rdata)
    );

endmodule

`default_nettype wire

// ==== rtl/vm16_core.sv ====
// Multi-cycle vm16 core, IF R1 R2 (ME) WB per instruction
// Program load only while reset is high, ending a cycle before reset falls
`timescale 1ns/100ps
`default_nettype none

module vm16_core import vm16_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                prog_we,
    input  logic [INSTR_AW-1:0] prog_addr,
    input  vm16_instr_t         prog_data,
    output apb_req_t            apb_req,
    input  apb_rsp_t            apb_rsp
);

    typedef enum logic [2:0] {
        S_IF,
        S_R1,
        S_R2,
        S_ME,
        S_WB
    } state_e;

    state_e               state;
    logic [INSTR_AW-1:0]  pc;
    logic [INSTR_AW-1:0]  imem_addr;
    logic [DATA_W-1:0]    imem_rdata;
    vm16_instr_t          instr;
    dec_ctrl_t            ctrl;
    logic [DATA_W-1:0]    rdd;
    logic [DATA_W-1:0]    rda;
    logic [DATA_W-1:0]    operand_b;
    logic [REG_SEL_W-1:0] reg_rs;
    logic [DATA_W-1:0]    reg_rdata;
    logic                 reg_we;
    logic [DATA_W-1:0]    reg_wdata;
    logic [DATA_W-1:0]    alu_c;
    logic [1:0]           flags;
    logic                 br_cond;
    logic                 br_taken;
    logic                 mem_req;
    logic                 mem_busy;
    logic [DATA_W-1:0]    mem_addr;
    logic [DATA_W-1:0]    mem_rdata;

    assign imem_addr = prog_we ? prog_addr : pc;

    // rd is read in R1, ra in R2
    assign reg_rs = (state == S_R1) ? instr.r.rd : instr.r.ra;

    always_comb begin
        if (ctrl.has_imm8) begin
            operand_b = {{(DATA_W-8){1'b0}}, instr.i.imm8};
        end else if (ctrl.has_imm4) begin
            operand_b = reg_rdata + {{(DATA_W-4){1'b0}}, instr.r.simm5[3:0]};
        end else begin
            operand_b = reg_rdata;
        end
    end

    always_comb begin
        case (instr.i.imm8)
            BR_U:    br_cond = 1'b1;
            BR_E:    br_cond = flags[FLAG_Z];
            BR_L:    br_cond = flags[FLAG_L];
            default: br_cond = 1'b0;
        endcase
    end

    assign br_taken  = ctrl.has_br && br_cond;
    assign mem_addr  = alu_c + {{(DATA_W-5){instr.r.simm5[4]}}, instr.r.simm5};
    assign reg_we    = ctrl.has_we && (state == S_WB);
    assign reg_wdata = ctrl.has_mem ? mem_rdata : alu_c;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IF;
            pc      <= '0;
            instr   <= '0;
            mem_req <= 1'b0;
            flags   <= '0;
        end else begin
            case (state)
                S_IF: begin
                    instr <= imem_rdata;
                    state <= S_R1;
                end
                S_R1: state <= S_R2;
                S_R2: begin
                    if (br_taken) begin
                        pc <= rdd[INSTR_AW-1:0];
                    end else if (pc != INSTR_AW'(INSTR_DEPTH - 1)) begin
                        pc <= pc + 1'b1;
                    end
                    mem_req <= ctrl.has_mem;
                    state   <= ctrl.has_mem ? S_ME : S_WB;
                end
                S_ME: begin
                    mem_req <= 1'b0;
                    if (!mem_busy) begin
                        state <= S_WB;
                    end
                end
                S_WB: begin
                    if (ctrl.has_cmp) begin
                        flags[FLAG_Z] <= alu_c[FLAG_Z];
                        flags[FLAG_L] <= alu_c[FLAG_L];
                    end
                    state <= S_IF;
                end
                default: state <= S_IF;
            endcase
        end
    end

    // Operand latches
    always_ff @(posedge clk) begin
        if (state == S_R1) begin
            rdd <= reg_rdata;
        end
        if (state == S_R2) begin
            rda <= operand_b;
        end
    end

    vm16_bram #(
        .DEPTH (INSTR_DEPTH)
    ) imem_i (
        .clk   (clk),
        .addr  (imem_addr),
        .wdata (prog_data),
        .we    (prog_we),
        .rdata (imem_rdata)
    );

    vm16_decoder decoder_i (
        .instr (instr),
        .ctrl  (ctrl)
    );

    vm16_regfile regfile_i (
        .clk   (clk),
        .reset (reset),
        .rs    (reg_rs),
        .rdata (reg_rdata),
        .we    (reg_we),
        .ws    (instr.r.rd),
        .wdata (reg_wdata)
    );

    vm16_alu alu_i (
        .op (ctrl.alu_op),
        .a  (rdd),
        .b  (rda),
        .c  (alu_c)
    );

    vm16_mmu mmu_i (
        .clk     (clk),
        .reset   (reset),
        .req     (mem_req),
        .addr    (mem_addr),
        .wdata   (rdd),
        .we      (ctrl.has_mem_we),
        .busy    (mem_busy),
        .rdata   (mem_rdata),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

endmodule

`default_nettype wire

// ==== tests/vm16_tb.sv ====
// Testbench for vm16_core that plays the APB slave and checks every bus transfer
// Run from the project root since the vectors file path is relative to it
`timescale 1ns/100ps
`default_nettype none

module vm16_tb import vm16_pkg::*; ();

    localparam int HALF_PERIOD  = 50;
    localparam int XFER_TIMEOUT = 500;
    localparam int IDLE_CYCLES  = 50;

    logic                clk;
    logic                reset;
    logic                prog_we;
    logic [INSTR_AW-1:0] prog_addr;
    vm16_instr_t         prog_data;
    apb_req_t            apb_req;
    apb_rsp_t            apb_rsp;

    integer seed;

    // Program image and the expected bus transfers in bus order
    logic [INSTR_AW-1:0] load_addr_q [$];
    logic [DATA_W-1:0]   load_word_q [$];
    logic                xfer_write_q [$];
    logic [DATA_W-1:0]   xfer_addr_q [$];
    logic [DATA_W-1:0]   xfer_data_q [$];

    vm16_core vm16_core_i (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: %s is 0x%h, expected 0x%h",
                                    $time, name, actual, expected));
        end
    endtask

    task automatic read_vectors();
        int                fd;
        int                n;
        string             line;
        byte               tag;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] d;
        fd = $fopen("tests/vm16_vectors.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open the vectors file tests/vm16_vectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 3) begin
                continue;
            end
            tag = line[0];
            if (tag == "#") begin
                continue;
            end
            n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
            if (n != 2) begin
                stop_on_error($sformatf("Vectors line has no address and data: %s", line));
            end
            case (tag)
                "P": begin
                    load_addr_q.push_back(a[INSTR_AW-1:0]);
                    load_word_q.push_back(d);
                end
                "R", "W": begin
                    xfer_write_q.push_back(tag == "W");
                    xfer_addr_q.push_back(a);
                    xfer_data_q.push_back(d);
                end
                default: stop_on_error($sformatf("Unknown tag in vectors line: %s", line));
            endcase
        end
        $fclose(fd);
        if (load_addr_q.size() == 0 || xfer_addr_q.size() == 0) begin
            stop_on_error("The vectors file holds no program or no bus transfers");
        end
    endtask

    // One word per cycle through the load port
    task automatic load_program();
        for (int i = 0; i < load_addr_q.size(); i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = load_addr_q[i];
            prog_data = load_word_q[i];
        end
        @(negedge clk);
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
    endtask

    // Access phase with the request fields frozen
    task automatic check_held(input apb_req_t held);
        check_value("psel", apb_req.psel, 1'b1);
        check_value("penable", apb_req.penable, 1'b1);
        check_value("paddr", apb_req.paddr, held.paddr);
        check_value("pwrite", apb_req.pwrite, held.pwrite);
        check_value("pwdata", apb_req.pwdata, held.pwdata);
    endtask

    task automatic serve_transfer(input int idx);
        apb_req_t          held;
        int                waits;
        int                guard;
        logic              is_write;
        logic [DATA_W-1:0] exp_addr;
        logic [DATA_W-1:0] exp_data;
        is_write = xfer_write_q[idx];
        exp_addr = xfer_addr_q[idx];
        exp_data = xfer_data_q[idx];
        guard    = 0;
        while (apb_req.psel !== 1'b1) begin
            check_value("penable", apb_req.penable, 1'b0);
            if (guard == XFER_TIMEOUT) begin
                stop_on_error($sformatf("Timeout: APB transfer %0d never started", idx));
            end
            guard++;
            @(negedge clk);
        end
        // Setup phase lasts exactly one cycle with penable low
        check_value("penable", apb_req.penable, 1'b0);
        held  = apb_req;
        waits = {$random(seed)} % 4;
        @(negedge clk);
        for (int k = 0; k < waits; k++) begin
            check_held(held);
            @(negedge clk);
        end
        check_held(held);
        check_value("pwrite", apb_req.pwrite, is_write);
        check_value("paddr", apb_req.paddr, exp_addr);
        if (is_write) begin
            check_value("pwdata", apb_req.pwdata, exp_data);
        end else begin
            apb_rsp.prdata = exp_data;
        end
        apb_rsp.pready = 1'b1;
        @(negedge clk);
        // Bus drops straight back to idle
        check_value("psel", apb_req.psel, 1'b0);
        check_value("penable", apb_req.penable, 1'b0);
        apb_rsp = '0;
    endtask

    initial begin
        seed      = 96;
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        apb_rsp   = '0;
        read_vectors();
        // Reset covers the load and then three idle cycles
        load_program();
        repeat (3) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < xfer_addr_q.size(); i++) begin
            serve_transfer(i);
        end
        // Core now spins on its final branch
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(negedge clk);
            if (apb_req.psel !== 1'b0) begin
                stop_on_error("An APB transfer started after the last expected one");
            end
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/vm16_vectors.txt ====
# P: instruction address, word. R: APB read address, returned data.
# W: expected APB write address, data. Hex values, R and W in bus order.
P 00 2690  # movi r6, 0x90
P 01 2112  # movi r1, 0x12
P 02 2234  # movi r2, 0x34
P 03 11C0  # sw r1, r6+0
P 04 12C1  # sw r2, r6+1
P 05 1B20  # mov r3, r1
P 06 2B5F  # add r3, r2
P 07 13C2  # sw r3, r6+2
P 08 2B3E  # sub r3, r1
P 09 13C3  # sw r3, r6+3
P 0A 2B45  # add r3, r2+5
P 0B 13C4  # sw r3, r6+4
P 0C 315E  # signed sub r1, r2
P 0D 11C5  # sw r1, r6+5
P 0E 245A  # movi r4, 0x5a
P 0F 250F  # movi r5, 0x0f
P 10 1B80  # mov r3, r4
P 11 3BA0  # or r3, r5
P 12 13C6  # sw r3, r6+6
P 13 1B80  # mov r3, r4
P 14 3BA1  # xor r3, r5
P 15 13C7  # sw r3, r6+7
P 16 1B80  # mov r3, r4
P 17 3BA2  # and r3, r5
P 18 13C8  # sw r3, r6+8
P 19 3BA3  # not r3, r5
P 1A 13C9  # sw r3, r6+9
P 1B 2003  # movi r0, 3
P 1C 1B80  # mov r3, r4
P 1D 3B04  # lshft r3, r0
P 1E 13CA  # sw r3, r6+10
P 1F 1B80  # mov r3, r4
P 20 3B05  # rshft r3, r0
P 21 13CB  # sw r3, r6+11
P 22 1402  # sw r4, r0+2 (TIM 0x0005)
P 23 0D02  # lw r5, r0+2 (TIM 0x0005)
P 24 15CC  # sw r5, r6+12
P 25 0DCD  # lw r5, r6+13 (APB read)
P 26 15CE  # sw r5, r6+14
P 27 4480  # cmp r4, r4
P 28 272B  # movi r7, 0x2b
P 29 4F01  # br.e r7, taken
P 2A 14CF  # sw r4, r6+15, skipped
P 2B 4080  # cmp r0, r4
P 2C 272F  # movi r7, 0x2f
P 2D 4F01  # br.e r7, not taken
P 2E 10D0  # sw r0, r6-16
P 2F 2732  # movi r7, 0x32
P 30 4F02  # br.l r7, taken
P 31 10D1  # sw r0, r6-15, skipped
P 32 14D2  # sw r4, r6-14
P 33 2734  # movi r7, 0x34
P 34 4F00  # br r7, loops here
W 0090 0012
W 0091 0034
W 0092 0046
W 0093 0034
W 0094 006D
W 0095 FFDE
W 0096 005F
W 0097 0055
W 0098 000A
W 0099 FFF0
W 009A 02D0
W 009B 000B
W 009C 005A
R 009D BEEF
W 009E BEEF
W 0080 0003
W 0082 005A

// ==== files.f ====
rtl/vm16_pkg.sv
rtl/vm16_bram.sv
rtl/vm16_regfile.sv
rtl/vm16_decoder.sv
rtl/vm16_alu.sv
rtl/vm16_mmu.sv
rtl/vm16_core.sv
tests/vm16_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = vm16_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
